/* rtl/disk_pkg.sv */
// disk subsystem package
// widths, controller identifiers, FSM state types and the per-disk
// register window and interrupt vector tables
package disk_pkg;

   //******************************
   // widths
   //******************************
   localparam int NUM_DISKS = 6;    // RK, DW, DM, DB, DX, MY
   localparam int DATA_W    = 16;   // bus data word
   localparam int ADR_W     = 16;   // I/O page address bits decoded
   localparam int VEC_W     = 9;    // vector handed to the CPU

   //******************************
   // types
   //******************************
   // controllers in SD grant priority order, highest first
   typedef enum logic [2:0] {
      DISK_RK,
      DISK_DW,
      DISK_DM,
      DISK_DB,
      DISK_DX,
      DISK_MY
   } disk_id_e;

   typedef enum logic {
      SD_IDLE,                      // card free
      SD_OWNED                      // one controller holds the card
   } sd_state_e;

   typedef enum logic [1:0] {
      VIC_IDLE,                     // waiting for a vector strobe
      VIC_ACK,                      // vector and ack presented
      VIC_WAIT_STB_LOW              // waiting for the strobe to drop
   } vic_state_e;

   //******************************
   // tables, indexed by disk_id_e
   //******************************
   localparam logic [ADR_W-1:0] DISK_BASE [NUM_DISKS] = '{
      16'o177400, 16'o174000, 16'o177440, 16'o176700, 16'o177170, 16'o172140
   };
   // low address bits ignored inside each window
   localparam logic [2:0] DISK_SPAN_BITS [NUM_DISKS] = '{
      3'd4, 3'd5, 3'd5, 3'd6, 3'd2, 3'd2
   };
   localparam logic [VEC_W-1:0] DISK_VECTOR [NUM_DISKS] = '{
      9'o220, 9'o300, 9'o210, 9'o254, 9'o264, 9'o170
   };

   // card levels with no owner
   localparam logic SD_IDLE_CS   = 1'b1;   // deselected
   localparam logic SD_IDLE_MOSI = 1'b1;   // line released high
   localparam logic SD_IDLE_SCLK = 1'b0;   // clock parked low

endpackage

/* rtl/sd_card_arbiter.sv */
// SD card access dispatcher
// filters each controller's request through two flops, grants the card
// to one controller in fixed priority and holds it until release
module sd_card_arbiter #(
   parameter int NUM_DISKS = disk_pkg::NUM_DISKS
) (
   input  logic                   sdclock,
   input  logic                   arst_n_i,
   input  logic [NUM_DISKS-1:0]   sd_req_i,      // raw requests, one per controller
   output logic [NUM_DISKS-1:0]   sd_ack_o,      // grants, one-hot or zero
   output disk_pkg::disk_id_e     owner_o,       // current owner
   output logic                   owner_valid_o  // card is owned
);

   import disk_pkg::*;

   logic [NUM_DISKS-1:0] req_s1;      // first filter stage
   logic [NUM_DISKS-1:0] req_flt;     // filtered requests
   sd_state_e            state;
   disk_id_e             owner_q;
   disk_id_e             win_id;      // highest priority filtered request
   logic                 any_req;

   //******************************
   // request filter
   //******************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_s1  <= '0;
         req_flt <= '0;
      end else begin
         req_s1  <= sd_req_i;
         req_flt <= req_s1;       // valid 2 edges after the raw level
      end
   end

   // lowest index wins, so scan from the top down
   always_comb begin
      win_id  = DISK_RK;
      any_req = 1'b0;
      for (int i = NUM_DISKS - 1; i >= 0; i--) begin
         if (req_flt[i]) begin
            win_id  = disk_id_e'(i);
            any_req = 1'b1;
         end
      end
   end

   //******************************
   // grant FSM
   //******************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state   <= SD_IDLE;
         owner_q <= DISK_RK;
      end else begin
         case (state)
            SD_IDLE: begin
               if (any_req) begin
                  owner_q <= win_id;   // lock the owner
                  state   <= SD_OWNED;
               end
            end
            SD_OWNED: begin
               if (!req_flt[owner_q]) begin
                  state <= SD_IDLE;    // owner let go
               end
            end
            default: state <= SD_IDLE;
         endcase
      end
   end

   assign owner_o       = owner_q;
   assign owner_valid_o = (state == SD_OWNED);

   // ack decoded from the owner register
   always_comb begin
      sd_ack_o = '0;
      if (state == SD_OWNED) begin
         sd_ack_o[owner_q] = 1'b1;
      end
   end

endmodule

/* rtl/sd_line_mux.sv */
// SD line multiplexer
// routes the owner's chip select, data and clock to the card, parks the
// lines when nobody owns it, and lights an active-low LED per request
module sd_line_mux #(
   parameter int NUM_DISKS = disk_pkg::NUM_DISKS
) (
   input  disk_pkg::disk_id_e     owner_i,
   input  logic                   owner_valid_i,
   input  logic [NUM_DISKS-1:0]   sd_req_i,       // raw requests, LEDs only
   input  logic [NUM_DISKS-1:0]   sd_cs_i,
   input  logic [NUM_DISKS-1:0]   sd_mosi_i,
   input  logic [NUM_DISKS-1:0]   sd_sclk_i,
   output logic                   sdcard_cs_o,
   output logic                   sdcard_mosi_o,
   output logic                   sdcard_sclk_o,
   output logic [NUM_DISKS-1:0]   disk_led_n_o    // lit while requesting
);

   import disk_pkg::*;

   //******************************
   // card lines
   //******************************
   always_comb begin
      if (owner_valid_i && (int'(owner_i) < NUM_DISKS)) begin
         sdcard_cs_o   = sd_cs_i[owner_i];
         sdcard_mosi_o = sd_mosi_i[owner_i];
         sdcard_sclk_o = sd_sclk_i[owner_i];
      end else begin
         sdcard_cs_o   = SD_IDLE_CS;     // card deselected
         sdcard_mosi_o = SD_IDLE_MOSI;
         sdcard_sclk_o = SD_IDLE_SCLK;
      end
   end

   // activity LEDs
   assign disk_led_n_o = ~sd_req_i;

endmodule

/* rtl/io_page_decode.sv */
// I/O page decoder for the disk register windows
// turns the bus address and strobe into one select per disk, collects
// the acks and returns the selected disk's read data
module io_page_decode #(
   parameter int NUM_DISKS = disk_pkg::NUM_DISKS
) (
   input  logic [disk_pkg::ADR_W-1:0]                  bus_adr_i,
   input  logic                                        bus_stb_i,
   input  logic [NUM_DISKS-1:0][disk_pkg::DATA_W-1:0]  disk_dat_i,      // read data per disk
   input  logic [NUM_DISKS-1:0]                        disk_bus_ack_i,
   output logic [NUM_DISKS-1:0]                        disk_sel_o,      // window selects
   output logic                                        bus_ack_o,
   output logic [disk_pkg::DATA_W-1:0]                 bus_dat_o
);

   import disk_pkg::*;

   //******************************
   // window compare
   //******************************
   // address bits above the span must match the base
   always_comb begin
      for (int i = 0; i < NUM_DISKS; i++) begin
         disk_sel_o[i] = bus_stb_i &&
            ((bus_adr_i >> DISK_SPAN_BITS[i]) == (DISK_BASE[i] >> DISK_SPAN_BITS[i]));
      end
   end

   //******************************
   // ack and read data
   //******************************
   assign bus_ack_o = |disk_bus_ack_i;    // any disk answering

   // windows never overlap, so an OR of gated words is enough
   always_comb begin
      bus_dat_o = '0;
      for (int i = 0; i < NUM_DISKS; i++) begin
         if (disk_sel_o[i]) begin
            bus_dat_o = bus_dat_o | disk_dat_i[i];
         end
      end
   end

endmodule

/* rtl/vec_irq_ctrl.sv */
// vectored interrupt controller for one bus priority level
// picks the lowest-index pending source on a CPU vector strobe, presents
// its vector and pulses the acknowledges once per strobe
module vec_irq_ctrl #(
   parameter int                          NUM_SRC = 6,
   parameter logic [disk_pkg::VEC_W-1:0]  VEC_TABLE [NUM_SRC] = '{default: '0}
) (
   input  logic                          sdclock,
   input  logic                          arst_n_i,
   input  logic [NUM_SRC-1:0]            irq_i,        // held until iack
   input  logic                          cpu_istb_i,   // vector strobe from CPU
   output logic                          cpu_irq_o,    // request to CPU
   output logic                          cpu_iack_o,   // vector valid
   output logic [disk_pkg::VEC_W-1:0]    cpu_vector_o,
   output logic [NUM_SRC-1:0]            irq_iack_o    // per-source ack pulse
);

   import disk_pkg::*;

   localparam int SRC_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

   vic_state_e       state;
   logic [SRC_W-1:0] pend_idx;   // lowest pending source
   logic [SRC_W-1:0] src_sel;    // source being served
   logic             any_irq;

   assign any_irq = |irq_i;

   always_comb begin
      pend_idx = '0;
      for (int i = NUM_SRC - 1; i >= 0; i--) begin
         if (irq_i[i]) begin
            pend_idx = SRC_W'(i);
         end
      end
   end

   //******************************
   // FSM
   //******************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state     <= VIC_IDLE;
         cpu_irq_o <= 1'b0;
      end else begin
         cpu_irq_o <= any_irq;              // follows sources one edge late
         case (state)
            VIC_IDLE: begin
               if (cpu_istb_i && any_irq) begin
                  state     <= VIC_ACK;
                  cpu_irq_o <= 1'b0;        // dropped while vector is out
               end
            end
            VIC_ACK:          state <= VIC_WAIT_STB_LOW;
            VIC_WAIT_STB_LOW: begin
               if (!cpu_istb_i) begin
                  state <= VIC_IDLE;        // one ack per strobe
               end
            end
            default:          state <= VIC_IDLE;
         endcase
      end
   end

   // served source captured with the grant
   always_ff @(posedge sdclock) begin
      if (state == VIC_IDLE && cpu_istb_i && any_irq) begin
         src_sel <= pend_idx;
      end
   end

   //******************************
   // outputs
   //******************************
   assign cpu_iack_o   = (state == VIC_ACK);
   assign cpu_vector_o = (state == VIC_ACK) ? VEC_TABLE[src_sel] : '0;

   always_comb begin
      irq_iack_o = '0;
      if (state == VIC_ACK) begin
         irq_iack_o[src_sel] = 1'b1;
      end
   end

endmodule

/* rtl/disk_top.sv */
// disk subsystem slice of the backplane
// SD card dispatcher and line mux, I/O page decoder for the disk
// registers and the priority 5 vectored interrupt controller
module disk_top #(
   parameter int NUM_DISKS = disk_pkg::NUM_DISKS
) (
   input  logic                                        sdclock,
   input  logic                                        arst_n_i,

   // controller side
   input  logic [NUM_DISKS-1:0]                        sd_req_i,       // card access requests
   output logic [NUM_DISKS-1:0]                        sd_ack_o,       // card grants
   input  logic [NUM_DISKS-1:0]                        sd_cs_i,
   input  logic [NUM_DISKS-1:0]                        sd_mosi_i,
   input  logic [NUM_DISKS-1:0]                        sd_sclk_i,
   input  logic [NUM_DISKS-1:0]                        irq_i,          // disk interrupts
   output logic [NUM_DISKS-1:0]                        disk_led_n_o,   // request LEDs

   // card side
   output logic                                        sdcard_cs_o,
   output logic                                        sdcard_mosi_o,
   output logic                                        sdcard_sclk_o,

   // bus side
   input  logic [disk_pkg::ADR_W-1:0]                  bus_adr_i,
   input  logic                                        bus_stb_i,
   input  logic [NUM_DISKS-1:0][disk_pkg::DATA_W-1:0]  disk_dat_i,
   input  logic [NUM_DISKS-1:0]                        disk_bus_ack_i,
   output logic [NUM_DISKS-1:0]                        disk_sel_o,
   output logic                                        bus_ack_o,
   output logic [disk_pkg::DATA_W-1:0]                 bus_dat_o,

   // CPU interrupt side
   input  logic                                        cpu_istb_i,     // vector strobe
   output logic                                        cpu_irq_o,
   output logic                                        cpu_iack_o,
   output logic [disk_pkg::VEC_W-1:0]                  cpu_vector_o,
   output logic [NUM_DISKS-1:0]                        irq_iack_o
);

   import disk_pkg::*;

   disk_id_e sd_owner;        // arbiter to mux
   logic     sd_owner_valid;

   //******************************
   // SD card dispatcher
   //******************************
   sd_card_arbiter #(
      .NUM_DISKS     (NUM_DISKS)
   ) u_arbiter (
      .sdclock       (sdclock),
      .arst_n_i      (arst_n_i),
      .sd_req_i      (sd_req_i),
      .sd_ack_o      (sd_ack_o),
      .owner_o       (sd_owner),
      .owner_valid_o (sd_owner_valid)
   );

   sd_line_mux #(
      .NUM_DISKS     (NUM_DISKS)
   ) u_line_mux (
      .owner_i       (sd_owner),
      .owner_valid_i (sd_owner_valid),
      .sd_req_i      (sd_req_i),
      .sd_cs_i       (sd_cs_i),
      .sd_mosi_i     (sd_mosi_i),
      .sd_sclk_i     (sd_sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o),
      .disk_led_n_o  (disk_led_n_o)
   );

   //******************************
   // register windows
   //******************************
   io_page_decode #(
      .NUM_DISKS      (NUM_DISKS)
   ) u_decode (
      .bus_adr_i      (bus_adr_i),
      .bus_stb_i      (bus_stb_i),
      .disk_dat_i     (disk_dat_i),
      .disk_bus_ack_i (disk_bus_ack_i),
      .disk_sel_o     (disk_sel_o),
      .bus_ack_o      (bus_ack_o),
      .bus_dat_o      (bus_dat_o)
   );

   // priority 5 interrupts, RK has the lowest index
   vec_irq_ctrl #(
      .NUM_SRC      (NUM_DISKS),
      .VEC_TABLE    (DISK_VECTOR)
   ) u_vic5 (
      .sdclock      (sdclock),
      .arst_n_i     (arst_n_i),
      .irq_i        (irq_i),
      .cpu_istb_i   (cpu_istb_i),
      .cpu_irq_o    (cpu_irq_o),
      .cpu_iack_o   (cpu_iack_o),
      .cpu_vector_o (cpu_vector_o),
      .irq_iack_o   (irq_iack_o)
   );

endmodule

/* tests/disk_top_asserts.sv */
// checker bound into the disk subsystem slice
// concurrent assertions on SD grant and routing, register decode and
// the vectored interrupt handshake
module disk_top_asserts #(
   parameter int NUM_DISKS = disk_pkg::NUM_DISKS
) (
   input logic                                       sdclock,
   input logic                                       arst_n_i,
   input logic [NUM_DISKS-1:0]                       sd_req_i, sd_ack_o, irq_i, irq_iack_o,
   input logic [NUM_DISKS-1:0]                       sd_cs_i, sd_mosi_i, sd_sclk_i, disk_led_n_o,
   input logic [NUM_DISKS-1:0]                       disk_bus_ack_i, disk_sel_o,
   input logic                                       sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o,
   input logic [disk_pkg::ADR_W-1:0]                 bus_adr_i,
   input logic                                       bus_stb_i, bus_ack_o,
   input logic [NUM_DISKS-1:0][disk_pkg::DATA_W-1:0] disk_dat_i,
   input logic [disk_pkg::DATA_W-1:0]                bus_dat_o,
   input logic                                       cpu_istb_i, cpu_irq_o, cpu_iack_o,
   input logic [disk_pkg::VEC_W-1:0]                 cpu_vector_o
);

   import disk_pkg::*;

   int   fail_cnt = 0;      // read by the testbench
   logic stb_served;        // vector already taken in this strobe

   // lowest set bit only
   function automatic logic [NUM_DISKS-1:0] low_bit(input logic [NUM_DISKS-1:0] v);
      return v & (-v);
   endfunction

   function automatic int low_idx(input logic [NUM_DISKS-1:0] v);
      for (int i = 0; i < NUM_DISKS; i++) begin
         if (v[i]) begin
            return i;
         end
      end
      return 0;
   endfunction

   // idle card grants the lowest requester, an owner keeps it while requesting
   function automatic logic [NUM_DISKS-1:0] exp_ack(input logic [NUM_DISKS-1:0] prev,
                                                    input logic [NUM_DISKS-1:0] req);
      return (prev == '0) ? low_bit(req) : (prev & req);
   endfunction

   function automatic logic [NUM_DISKS-1:0] exp_sel(input logic [ADR_W-1:0] adr,
                                                    input logic stb);
      logic [ADR_W-1:0] mask;
      exp_sel = '0;
      for (int i = 0; i < NUM_DISKS; i++) begin
         mask       = ~((ADR_W'(1) << DISK_SPAN_BITS[i]) - ADR_W'(1));   // window bits
         exp_sel[i] = stb && ((adr & mask) == (DISK_BASE[i] & mask));
      end
   endfunction

   function automatic logic [DATA_W-1:0] exp_dat(input logic [NUM_DISKS-1:0] sel,
                                                 input logic [NUM_DISKS-1:0][DATA_W-1:0] dat);
      for (int i = 0; i < NUM_DISKS; i++) begin
         if (sel[i]) begin
            return dat[i];
         end
      end
      return '0;
   endfunction

   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stb_served <= 1'b0;
      end else begin
         stb_served <= cpu_istb_i && (stb_served || cpu_iack_o);   // cleared by strobe low
      end
   end

   //******************************
   // SD card access
   //******************************
   a_reset: assert property (@(posedge sdclock)
      !arst_n_i |-> (sd_ack_o == '0 && !cpu_iack_o && !cpu_irq_o))
      else begin
         $error("error sd_ack_o %h cpu_iack_o %h cpu_irq_o %h in reset",
                sd_ack_o, cpu_iack_o, cpu_irq_o);
         fail_cnt++;
      end

   a_one_owner: assert property (@(posedge sdclock) $onehot0(sd_ack_o))
      else begin
         $error("error sd_ack_o %h", sd_ack_o);
         fail_cnt++;
      end

   // filtered request lags 2 edges, grant register one more
   a_grant: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      1'b1 |=> (sd_ack_o == exp_ack($past(sd_ack_o), $past(sd_req_i, 3))))
      else begin
         $error("error sd_ack_o %h sd_req_i %h", sd_ack_o, sd_req_i);
         fail_cnt++;
      end

   a_lines: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      (disk_led_n_o == ~sd_req_i) &&
      ({sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o} == ((sd_ack_o == '0) ?
         {SD_IDLE_CS, SD_IDLE_MOSI, SD_IDLE_SCLK} :
         {|(sd_cs_i & sd_ack_o), |(sd_mosi_i & sd_ack_o), |(sd_sclk_i & sd_ack_o)})))
      else begin
         $error("error sdcard_cs/mosi/sclk %h %h %h disk_led_n_o %h sd_ack_o %h",
                sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o, disk_led_n_o, sd_ack_o);
         fail_cnt++;
      end

   //******************************
   // register windows
   //******************************
   a_decode: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      (disk_sel_o == exp_sel(bus_adr_i, bus_stb_i)) && (bus_ack_o == |disk_bus_ack_i) &&
      (bus_dat_o == exp_dat(exp_sel(bus_adr_i, bus_stb_i), disk_dat_i)))
      else begin
         $error("error disk_sel_o %h bus_ack_o %h bus_dat_o %h at bus_adr_i %h",
                disk_sel_o, bus_ack_o, bus_dat_o, bus_adr_i);
         fail_cnt++;
      end

   //******************************
   // interrupts
   //******************************
   a_vector: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      ($rose(cpu_istb_i) && irq_i != '0) |=> (cpu_iack_o &&
      irq_iack_o == low_bit($past(irq_i)) &&
      cpu_vector_o == DISK_VECTOR[low_idx($past(irq_i))]))
      else begin
         $error("error cpu_iack_o %h cpu_vector_o %h irq_iack_o %h",
                cpu_iack_o, cpu_vector_o, irq_iack_o);
         fail_cnt++;
      end

   a_quiet: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      !cpu_iack_o |-> (cpu_vector_o == '0 && irq_iack_o == '0))
      else begin
         $error("error cpu_vector_o %h irq_iack_o %h", cpu_vector_o, irq_iack_o);
         fail_cnt++;
      end

   a_once: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      (stb_served && cpu_istb_i) |-> !cpu_iack_o)
      else begin
         $error("error cpu_iack_o %h repeated in a held strobe", cpu_iack_o);
         fail_cnt++;
      end

   a_cpu_irq: assert property (@(posedge sdclock) disable iff (!arst_n_i)
      1'b1 |=> (cpu_irq_o == ((|$past(irq_i)) && !cpu_iack_o)))
      else begin
         $error("error cpu_irq_o %h irq_i %h", cpu_irq_o, irq_i);
         fail_cnt++;
      end

endmodule

bind disk_top disk_top_asserts #(.NUM_DISKS(NUM_DISKS)) u_asserts (.*);

/* tests/tb_disk_top.sv */
// testbench for the disk subsystem slice
// drives SD requests, bus cycles and interrupt strobes; the bound
// assertions do the checking
module tb_disk_top;

   import disk_pkg::*;

   localparam int TMO = 50;   // cycles allowed per wait

   logic                             sdclock;
   logic                             arst_n_i;
   logic [NUM_DISKS-1:0]             sd_req_i, sd_ack_o, irq_i, irq_iack_o;
   logic [NUM_DISKS-1:0]             sd_cs_i, sd_mosi_i, sd_sclk_i, disk_led_n_o;
   logic [NUM_DISKS-1:0]             disk_bus_ack_i, disk_sel_o;
   logic                             sdcard_cs_o, sdcard_mosi_o, sdcard_sclk_o;
   logic [ADR_W-1:0]                 bus_adr_i;
   logic                             bus_stb_i, bus_ack_o;
   logic [NUM_DISKS-1:0][DATA_W-1:0] disk_dat_i;
   logic [DATA_W-1:0]                bus_dat_o;
   logic                             cpu_istb_i, cpu_irq_o, cpu_iack_o;
   logic [VEC_W-1:0]                 cpu_vector_o;

   logic [31:0] lcg_state = 32'd33388;
   int          timeouts  = 0;

   disk_top #(.NUM_DISKS(NUM_DISKS)) UUT (.*);

   initial begin
      sdclock = 1'b0;
      forever #5 sdclock = ~sdclock;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 8;   // low bits are weak
   endfunction

   // one cycle with fresh card lines from every controller
   task automatic step();
      @(posedge sdclock);
      #1;
      sd_cs_i   = NUM_DISKS'(lcg_next());
      sd_mosi_i = NUM_DISKS'(lcg_next());
      sd_sclk_i = NUM_DISKS'(lcg_next());
   endtask

   task automatic wait_sd(input logic [NUM_DISKS-1:0] mask, input logic granted);
      int n;
      n = 0;
      while ((|(sd_ack_o & mask)) != granted && n < TMO) begin
         step();
         n++;
      end
      if ((|(sd_ack_o & mask)) != granted) begin
         $display("timeout: SD grant for requests %h did not go %s",
                  mask, granted ? "high" : "low");
         timeouts++;
      end
   endtask

   task automatic wait_iack();
      int n;
      n = 0;
      while (!cpu_iack_o && n < TMO) begin
         step();
         n++;
      end
      if (!cpu_iack_o) begin
         $display("timeout: no interrupt vector for pending sources %h", irq_i);
         timeouts++;
      end
   endtask

   task automatic bus_cycle(input logic [ADR_W-1:0] adr, input logic force_stb);
      logic [31:0] r;
      r              = lcg_next();
      bus_adr_i      = adr;
      bus_stb_i      = force_stb || (r[3:0] != 4'd0);   // mostly strobed
      disk_bus_ack_i = NUM_DISKS'(r >> 4);
      for (int i = 0; i < NUM_DISKS; i++) begin
         disk_dat_i[i] = DATA_W'(lcg_next());
      end
      step();
   endtask

   initial begin
      logic [NUM_DISKS-1:0] own;
      arst_n_i       = 1'b1;
      sd_req_i       = '0;
      sd_cs_i        = '0;
      sd_mosi_i      = '0;
      sd_sclk_i      = '0;
      irq_i          = '0;
      bus_adr_i      = '0;
      bus_stb_i      = 1'b0;
      disk_dat_i     = '0;
      disk_bus_ack_i = '0;
      cpu_istb_i     = 1'b0;
      #2 arst_n_i = 1'b0;
      repeat (16) @(posedge sdclock);
      #1 arst_n_i = 1'b1;

      //******************************
      // SD card dispatcher
      //******************************
      for (int i = 0; i < NUM_DISKS; i++) begin   // lone requests
         sd_req_i[i] = 1'b1;
         wait_sd(NUM_DISKS'(1) << i, 1'b1);
         repeat (4) step();
         sd_req_i[i] = 1'b0;
         wait_sd('1, 1'b0);
      end
      sd_req_i = '1;                              // all together and owners leave in turn
      for (int k = 0; k < NUM_DISKS; k++) begin
         wait_sd('1, 1'b1);
         repeat (3) step();
         own      = sd_ack_o;
         sd_req_i = sd_req_i & ~own;
         wait_sd(own, 1'b0);
      end
      for (int k = 0; k < 400; k++) begin         // overlapping random toggles
         if (k % 3 == 0) begin
            sd_req_i = sd_req_i ^ (NUM_DISKS'(1) << (lcg_next() % NUM_DISKS));
         end
         step();
      end
      sd_req_i = '0;
      wait_sd('1, 1'b0);

      //******************************
      // register windows
      //******************************
      for (int i = 0; i < NUM_DISKS; i++) begin
         bus_cycle(DISK_BASE[i], 1'b1);
         bus_cycle(DISK_BASE[i] | ((ADR_W'(1) << DISK_SPAN_BITS[i]) - ADR_W'(1)), 1'b1);
         bus_cycle(DISK_BASE[i] - ADR_W'(1), 1'b1);     // just below
      end
      for (int k = 0; k < 200; k++) begin
         bus_cycle(ADR_W'(lcg_next()) | 16'o170000, 1'b0);
      end
      bus_stb_i = 1'b0;

      //******************************
      // interrupts
      //******************************
      for (int k = 0; k < 8; k++) begin
         irq_i = NUM_DISKS'(lcg_next());
         repeat (2) step();
         for (int j = 0; j <= NUM_DISKS; j++) begin
            cpu_istb_i = 1'b1;
            if (irq_i != '0) begin
               wait_iack();
               irq_i = irq_i & ~irq_iack_o;        // source drops on its ack
            end
            repeat (4) step();                     // strobe held
            cpu_istb_i = 1'b0;
            repeat (3) step();
         end
      end

      step();
      $display("assertion failures %0d, timeouts %0d", UUT.u_asserts.fail_cnt, timeouts);
      if (UUT.u_asserts.fail_cnt == 0 && timeouts == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
rtl/disk_pkg.sv
rtl/sd_card_arbiter.sv
rtl/sd_line_mux.sv
rtl/io_page_decode.sv
rtl/vec_irq_ctrl.sv
rtl/disk_top.sv
tests/disk_top_asserts.sv
tests/tb_disk_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_disk_top
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+10000
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
